/* verilog/mem_bridge_pkg.sv */
`default_nettype none

package mem_bridge_pkg;

  parameter int unsigned addr_width = 32;
  parameter int unsigned data_width = 32;
  parameter int unsigned id_width = 4;
  parameter int unsigned strb_width = data_width / 8;

  // axi attribute codes used by the bridges
  parameter logic [3:0] axi_cache_cacheable = 4'hf;
  parameter logic [3:0] axi_cache_device = 4'h0;
  parameter logic [1:0] axi_burst_incr = 2'b01;
  parameter logic [7:0] axi_len_single = 8'h00;

  // same code on the sram-like side and in axsize
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } access_size_e;

  typedef enum logic [2:0] {
    st_idle        = 3'd0,
    st_read_addr   = 3'd1,
    st_read_data   = 3'd2,
    st_write_issue = 3'd3,
    st_write_resp  = 3'd4
  } bridge_state_e;

  typedef struct packed {
    logic                  req;
    logic                  wr;
    access_size_e          size;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  addr_ok;
    logic                  data_ok;
    logic [data_width-1:0] rdata;
  } mem_rsp_t;

  // request after segment translation
  typedef struct packed {
    logic                  req;
    logic                  wr;
    access_size_e          size;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic                  cached;
  } phys_req_t;

  typedef struct packed {
    logic [id_width-1:0]   arid;
    logic [addr_width-1:0] araddr;
    logic [7:0]            arlen;
    logic [2:0]            arsize;
    logic [1:0]            arburst;
    logic [3:0]            arcache;
    logic                  arvalid;
  } axi_ar_t;

  typedef struct packed {
    logic [id_width-1:0]   awid;
    logic [addr_width-1:0] awaddr;
    logic [7:0]            awlen;
    logic [2:0]            awsize;
    logic [1:0]            awburst;
    logic [3:0]            awcache;
    logic                  awvalid;
  } axi_aw_t;

  typedef struct packed {
    logic [id_width-1:0]   wid;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wlast;
    logic                  wvalid;
  } axi_w_t;

  // slave side signals seen by one bridge
  typedef struct packed {
    logic                  arready;
    logic [data_width-1:0] rdata;
    logic                  rvalid;
    logic                  rlast;
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
  } axi_rsp_t;

endpackage

`default_nettype wire

/* verilog/seg_map.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_map
  import mem_bridge_pkg::*;
#(
  parameter int unsigned num_channels = 2
) (
  input  mem_req_t  cpu_req  [num_channels],
  output phys_req_t phys_req [num_channels]
);

  // kseg0 is 3'b100 and kseg1 is 3'b101 in the top address bits
  localparam logic [2:0] seg_kseg0 = 3'b100;
  localparam logic [2:0] seg_kseg1 = 3'b101;

  logic [num_channels-1:0] is_kseg0;
  logic [num_channels-1:0] is_kseg1;

  always_comb begin
    for (int ch = 0; ch < num_channels; ch++) begin
      is_kseg0[ch] = (cpu_req[ch].addr[addr_width-1 -: 3] == seg_kseg0);
      is_kseg1[ch] = (cpu_req[ch].addr[addr_width-1 -: 3] == seg_kseg1);
    end
  end

  always_comb begin
    for (int ch = 0; ch < num_channels; ch++) begin
      phys_req[ch].req = cpu_req[ch].req;
      phys_req[ch].wr = cpu_req[ch].wr;
      phys_req[ch].size = cpu_req[ch].size;
      phys_req[ch].wdata = cpu_req[ch].wdata;

      // unmapped segments drop the top three bits
      if (is_kseg0[ch] || is_kseg1[ch]) begin
        phys_req[ch].addr = {3'b000, cpu_req[ch].addr[addr_width-4:0]};
      end else begin
        phys_req[ch].addr = cpu_req[ch].addr;
      end

      // only kseg1 goes out as device access
      phys_req[ch].cached = ~is_kseg1[ch];
    end
  end

endmodule

`default_nettype wire

/* verilog/sram_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_axi_bridge
  import mem_bridge_pkg::*;
#(
  parameter int unsigned channel_id = 0
) (
  input  logic      clk,
  input  logic      reset,
  input  phys_req_t phys_req,
  output mem_rsp_t  cpu_rsp,
  output axi_ar_t   axi_ar,
  output axi_aw_t   axi_aw,
  output axi_w_t    axi_w,
  output logic      rready,
  output logic      bready,
  input  axi_rsp_t  axi_rsp
);

  localparam logic [id_width-1:0] axi_id = id_width'(channel_id);

  bridge_state_e state_q;
  bridge_state_e state_d;

  logic aw_done_q;
  logic aw_done_d;
  logic w_done_q;
  logic w_done_d;
  logic data_ok_q;
  logic data_ok_d;

  // request held for the whole transfer
  phys_req_t             req_q;
  logic [data_width-1:0] rdata_q;

  logic                  accept;
  logic                  ar_hs;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  r_hs;
  logic                  b_hs;
  logic [3:0]            cache_code;
  logic [strb_width-1:0] strb;

  // new request only taken while idle
  assign accept = (state_q == st_idle) && phys_req.req;

  assign ar_hs = axi_ar.arvalid && axi_rsp.arready;
  assign aw_hs = axi_aw.awvalid && axi_rsp.awready;
  assign w_hs = axi_w.wvalid && axi_rsp.wready;
  assign r_hs = rready && axi_rsp.rvalid;
  assign b_hs = bready && axi_rsp.bvalid;

  assign cache_code = req_q.cached ? axi_cache_cacheable : axi_cache_device;

  // byte lanes from size and low address bits
  always_comb begin
    case (req_q.size)
      size_byte: strb = 4'b0001 << req_q.addr[1:0];
      size_half: strb = req_q.addr[1] ? 4'b1100 : 4'b0011;
      default:   strb = 4'b1111;
    endcase
  end

  always_comb begin
    state_d = state_q;
    aw_done_d = aw_done_q;
    w_done_d = w_done_q;
    data_ok_d = 1'b0;

    case (state_q)
      st_idle: begin
        if (accept) begin
          aw_done_d = 1'b0;
          w_done_d = 1'b0;
          state_d = phys_req.wr ? st_write_issue : st_read_addr;
        end
      end
      st_read_addr: begin
        if (ar_hs) begin
          state_d = st_read_data;
        end
      end
      st_read_data: begin
        if (r_hs) begin
          data_ok_d = 1'b1;
          state_d = st_idle;
        end
      end
      st_write_issue: begin
        // aw and w may complete in either order
        aw_done_d = aw_done_q | aw_hs;
        w_done_d = w_done_q | w_hs;
        if (aw_done_d && w_done_d) begin
          state_d = st_write_resp;
        end
      end
      st_write_resp: begin
        if (b_hs) begin
          data_ok_d = 1'b1;
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      aw_done_q <= 1'b0;
      w_done_q <= 1'b0;
      data_ok_q <= 1'b0;
    end else begin
      state_q <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q <= w_done_d;
      data_ok_q <= data_ok_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= phys_req;
    end
    if (r_hs) begin
      rdata_q <= axi_rsp.rdata;
    end
  end

  // read address channel
  always_comb begin
    axi_ar.arid = axi_id;
    axi_ar.araddr = req_q.addr;
    axi_ar.arlen = axi_len_single;
    axi_ar.arsize = {1'b0, req_q.size};
    axi_ar.arburst = axi_burst_incr;
    axi_ar.arcache = cache_code;
    axi_ar.arvalid = (state_q == st_read_addr);
  end

  // write address channel
  always_comb begin
    axi_aw.awid = axi_id;
    axi_aw.awaddr = req_q.addr;
    axi_aw.awlen = axi_len_single;
    axi_aw.awsize = {1'b0, req_q.size};
    axi_aw.awburst = axi_burst_incr;
    axi_aw.awcache = cache_code;
    axi_aw.awvalid = (state_q == st_write_issue) && !aw_done_q;
  end

  // write data, cpu already places data on its lanes
  always_comb begin
    axi_w.wid = axi_id;
    axi_w.wdata = req_q.wdata;
    axi_w.wstrb = strb;
    axi_w.wlast = 1'b1;
    axi_w.wvalid = (state_q == st_write_issue) && !w_done_q;
  end

  assign rready = (state_q == st_read_data);
  assign bready = (state_q == st_write_resp);

  always_comb begin
    cpu_rsp.addr_ok = accept;
    cpu_rsp.data_ok = data_ok_q;
    cpu_rsp.rdata = rdata_q;
  end

endmodule

`default_nettype wire

/* verilog/mem_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bridge_top
  import mem_bridge_pkg::*;
#(
  parameter int unsigned num_channels = 2
) (
  input  logic     clk,
  input  logic     reset,
  // channel 0 instruction side, channel 1 data side
  input  mem_req_t cpu_req [num_channels],
  output mem_rsp_t cpu_rsp [num_channels],
  output axi_ar_t  axi_ar  [num_channels],
  output axi_aw_t  axi_aw  [num_channels],
  output axi_w_t   axi_w   [num_channels],
  output logic     rready  [num_channels],
  output logic     bready  [num_channels],
  input  axi_rsp_t axi_rsp [num_channels]
);

  phys_req_t phys_req [num_channels];

  seg_map #(
    .num_channels (num_channels)
  ) seg_map_i (
    .cpu_req  (cpu_req),
    .phys_req (phys_req)
  );

  // one bridge and one axi port per channel
  for (genvar ch = 0; ch < num_channels; ch++) begin : gen_bridge
    sram_axi_bridge #(
      .channel_id (ch)
    ) bridge_i (
      .clk      (clk),
      .reset    (reset),
      .phys_req (phys_req[ch]),
      .cpu_rsp  (cpu_rsp[ch]),
      .axi_ar   (axi_ar[ch]),
      .axi_aw   (axi_aw[ch]),
      .axi_w    (axi_w[ch]),
      .rready   (rready[ch]),
      .bready   (bready[ch]),
      .axi_rsp  (axi_rsp[ch])
    );
  end

endmodule

`default_nettype wire

/* verif/mem_bridge_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bridge_chk
  import mem_bridge_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input axi_ar_t  axi_ar,
  input axi_aw_t  axi_aw,
  input axi_w_t   axi_w,
  input axi_rsp_t axi_rsp
);

  // read address held until the slave takes it
  ar_hold: assert property (@(posedge clk) disable iff (reset)
    (axi_ar.arvalid && !axi_rsp.arready) |=> (axi_ar.arvalid && $stable(axi_ar.araddr)))
    else $error("arvalid dropped or araddr changed before arready");

  aw_hold: assert property (@(posedge clk) disable iff (reset)
    (axi_aw.awvalid && !axi_rsp.awready) |=> (axi_aw.awvalid && $stable(axi_aw.awaddr)))
    else $error("awvalid dropped or awaddr changed before awready");

  // write data and lanes stay put under back-pressure
  w_hold: assert property (@(posedge clk) disable iff (reset)
    (axi_w.wvalid && !axi_rsp.wready) |=>
      (axi_w.wvalid && $stable(axi_w.wdata) && $stable(axi_w.wstrb)))
    else $error("wvalid dropped or wdata changed before wready");

endmodule

bind sram_axi_bridge mem_bridge_chk chk_i (
  .clk     (clk),
  .reset   (reset),
  .axi_ar  (axi_ar),
  .axi_aw  (axi_aw),
  .axi_w   (axi_w),
  .axi_rsp (axi_rsp)
);

`default_nettype wire

/* verif/mem_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bridge_tb
  import mem_bridge_pkg::*;
();

  localparam int num_channels = 2;
  localparam int num_tests = 5;
  localparam int cycles_per_test = 200;
  localparam int clk_period = 40;
  localparam int wait_limit = 100;

  logic     clk;
  logic     reset;
  mem_req_t cpu_req [num_channels];
  mem_rsp_t cpu_rsp [num_channels];
  axi_ar_t  axi_ar  [num_channels];
  axi_aw_t  axi_aw  [num_channels];
  axi_w_t   axi_w   [num_channels];
  logic     rready  [num_channels];
  logic     bready  [num_channels];
  axi_rsp_t axi_rsp [num_channels];

  int          errors;
  int          checks;
  logic        rand_delay;
  logic [31:0] slave_rng;
  logic [31:0] stim_rng;

  // slave and expected contents by word address
  logic [31:0] slave_mem [logic [31:0]];
  logic [31:0] model_mem [logic [31:0]];

  // last captured requests and delay counters per slave
  axi_ar_t cap_ar     [num_channels];
  axi_aw_t cap_aw     [num_channels];
  axi_w_t  cap_w      [num_channels];
  int      addr_count [num_channels];
  int      ar_cnt     [num_channels];
  int      r_cnt      [num_channels];
  int      aw_cnt     [num_channels];
  int      w_cnt      [num_channels];
  int      b_cnt      [num_channels];
  logic    r_pend     [num_channels];
  logic    aw_got     [num_channels];
  logic    w_got      [num_channels];

  mem_bridge_top #(
    .num_channels (num_channels)
  ) dut_i (
    .clk     (clk),
    .reset   (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .axi_ar  (axi_ar),
    .axi_aw  (axi_aw),
    .axi_w   (axi_w),
    .rready  (rready),
    .bready  (bready),
    .axi_rsp (axi_rsp)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int pick_delay();
    if (!rand_delay) begin
      return 0;
    end
    slave_rng = lcg_next(slave_rng);
    return int'(slave_rng[17:16]);
  endfunction

  function automatic logic [31:0] pattern_word(input logic [31:0] word);
    return word ^ 32'h5a5a_5a5a;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  // kseg0 and kseg1 both lose the top three bits
  function automatic logic [31:0] phys_of(input logic [31:0] v);
    if (v >= 32'h8000_0000 && v <= 32'hbfff_ffff) begin
      return v & 32'h1fff_ffff;
    end
    return v;
  endfunction

  function automatic logic [3:0] cache_of(input logic [31:0] v);
    return (v >= 32'ha000_0000 && v <= 32'hbfff_ffff) ? 4'h0 : 4'hf;
  endfunction

  function automatic logic [3:0] lane_mask(input access_size_e size, input logic [1:0] low);
    case (size)
      size_byte: return 4'b0001 << low;
      size_half: return 4'b0011 << {low[1], 1'b0};
      default:   return 4'b1111;
    endcase
  endfunction

  task automatic check_field(input int ch, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] ch%0d %s: got 0x%08h, expected 0x%08h", ch, name, got, exp);
      errors++;
    end
  endtask

  // one slave step per falling edge
  // readies and responses last one cycle
  task automatic serve_channel(input int ch);
    logic [31:0] word;
    logic [31:0] old;
    if (axi_rsp[ch].arready) begin
      axi_rsp[ch].arready = 1'b0;
      r_pend[ch] = 1'b1;
      r_cnt[ch] = pick_delay();
    end else if (axi_ar[ch].arvalid) begin
      if (ar_cnt[ch] == 0) begin
        axi_rsp[ch].arready = 1'b1;
        cap_ar[ch] = axi_ar[ch];
        addr_count[ch]++;
        ar_cnt[ch] = pick_delay();
      end else begin
        ar_cnt[ch]--;
      end
    end
    if (axi_rsp[ch].rvalid) begin
      axi_rsp[ch].rvalid = 1'b0;
      axi_rsp[ch].rlast = 1'b0;
    end else if (r_pend[ch]) begin
      if (r_cnt[ch] == 0) begin
        word = {cap_ar[ch].araddr[31:2], 2'b00};
        axi_rsp[ch].rdata = slave_mem.exists(word) ? slave_mem[word] : pattern_word(word);
        axi_rsp[ch].rvalid = 1'b1;
        axi_rsp[ch].rlast = 1'b1;
        r_pend[ch] = 1'b0;
      end else begin
        r_cnt[ch]--;
      end
    end
    if (axi_rsp[ch].awready) begin
      axi_rsp[ch].awready = 1'b0;
      aw_got[ch] = 1'b1;
    end else if (axi_aw[ch].awvalid) begin
      if (aw_cnt[ch] == 0) begin
        axi_rsp[ch].awready = 1'b1;
        cap_aw[ch] = axi_aw[ch];
        addr_count[ch]++;
        aw_cnt[ch] = pick_delay();
      end else begin
        aw_cnt[ch]--;
      end
    end
    if (axi_rsp[ch].wready) begin
      axi_rsp[ch].wready = 1'b0;
      w_got[ch] = 1'b1;
    end else if (axi_w[ch].wvalid) begin
      if (w_cnt[ch] == 0) begin
        axi_rsp[ch].wready = 1'b1;
        cap_w[ch] = axi_w[ch];
        w_cnt[ch] = pick_delay();
      end else begin
        w_cnt[ch]--;
      end
    end
    if (axi_rsp[ch].bvalid) begin
      axi_rsp[ch].bvalid = 1'b0;
    end else if (aw_got[ch] && w_got[ch]) begin
      if (b_cnt[ch] == 0) begin
        word = {cap_aw[ch].awaddr[31:2], 2'b00};
        old = slave_mem.exists(word) ? slave_mem[word] : pattern_word(word);
        slave_mem[word] = merge_lanes(old, cap_w[ch].wdata, cap_w[ch].wstrb);
        axi_rsp[ch].bvalid = 1'b1;
        aw_got[ch] = 1'b0;
        w_got[ch] = 1'b0;
        b_cnt[ch] = pick_delay();
      end else begin
        b_cnt[ch]--;
      end
    end
  endtask

  initial begin
    slave_rng = 32'h525d;
    for (int ch = 0; ch < num_channels; ch++) begin
      axi_rsp[ch] = '0;
      addr_count[ch] = 0;
      ar_cnt[ch] = 0;
      r_cnt[ch] = 0;
      aw_cnt[ch] = 0;
      w_cnt[ch] = 0;
      b_cnt[ch] = 0;
      r_pend[ch] = 1'b0;
      aw_got[ch] = 1'b0;
      w_got[ch] = 1'b0;
    end
    forever begin
      @(negedge clk);
      for (int ch = 0; ch < num_channels; ch++) begin
        if (!reset) serve_channel(ch);
      end
    end
  end

  // one sram-like transfer checked against the segment rule
  task automatic do_access(input int ch, input logic wr, input access_size_e size,
                           input logic [31:0] vaddr, input logic [31:0] wdata);
    logic [31:0] paddr;
    logic [31:0] word;
    logic [31:0] old;
    logic [3:0]  mask;
    int          start_count;
    int          cycles;
    paddr = phys_of(vaddr);
    word = {paddr[31:2], 2'b00};
    mask = lane_mask(size, vaddr[1:0]);
    start_count = addr_count[ch];
    cycles = 0;
    @(negedge clk);
    cpu_req[ch].req = 1'b1;
    cpu_req[ch].wr = wr;
    cpu_req[ch].size = size;
    cpu_req[ch].addr = vaddr;
    cpu_req[ch].wdata = wdata;
    #(clk_period / 4);
    // the bridge is idle here, so the request is taken at once
    check_field(ch, "addr_ok", 32'(cpu_rsp[ch].addr_ok), 32'd1);
    while (!cpu_rsp[ch].addr_ok && cycles < wait_limit) begin
      @(negedge clk);
      #(clk_period / 4);
      cycles++;
    end
    @(negedge clk);
    cpu_req[ch].req = 1'b0;
    while (!cpu_rsp[ch].data_ok && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    assert (cpu_rsp[ch].data_ok) else begin
      $display("channel %0d: request at 0x%08h got no data_ok in time", ch, vaddr);
      errors++;
    end
    if (!cpu_rsp[ch].data_ok) begin
      return;
    end
    check_field(ch, "address handshakes", 32'(addr_count[ch] - start_count), 32'd1);
    if (wr) begin
      check_field(ch, "awaddr", cap_aw[ch].awaddr, paddr);
      check_field(ch, "awcache", 32'(cap_aw[ch].awcache), 32'(cache_of(vaddr)));
      check_field(ch, "awid", 32'(cap_aw[ch].awid), 32'(ch));
      check_field(ch, "awlen", 32'(cap_aw[ch].awlen), 32'd0);
      check_field(ch, "awsize", 32'(cap_aw[ch].awsize), 32'(size));
      check_field(ch, "awburst", 32'(cap_aw[ch].awburst), 32'd1);
      check_field(ch, "wid", 32'(cap_w[ch].wid), 32'(ch));
      check_field(ch, "wdata", cap_w[ch].wdata, wdata);
      check_field(ch, "wstrb", 32'(cap_w[ch].wstrb), 32'(mask));
      check_field(ch, "wlast", 32'(cap_w[ch].wlast), 32'd1);
      old = model_mem.exists(word) ? model_mem[word] : pattern_word(word);
      model_mem[word] = merge_lanes(old, wdata, mask);
    end else begin
      check_field(ch, "araddr", cap_ar[ch].araddr, paddr);
      check_field(ch, "arcache", 32'(cap_ar[ch].arcache), 32'(cache_of(vaddr)));
      check_field(ch, "arid", 32'(cap_ar[ch].arid), 32'(ch));
      check_field(ch, "arlen", 32'(cap_ar[ch].arlen), 32'd0);
      check_field(ch, "arsize", 32'(cap_ar[ch].arsize), 32'(size));
      check_field(ch, "arburst", 32'(cap_ar[ch].arburst), 32'd1);
      old = model_mem.exists(word) ? model_mem[word] : pattern_word(word);
      check_field(ch, "rdata", cpu_rsp[ch].rdata, old);
    end
  endtask

  task automatic reset_idle_outputs();
    for (int ch = 0; ch < num_channels; ch++) begin
      check_field(ch, "arvalid", 32'(axi_ar[ch].arvalid), 32'd0);
      check_field(ch, "awvalid", 32'(axi_aw[ch].awvalid), 32'd0);
      check_field(ch, "wvalid", 32'(axi_w[ch].wvalid), 32'd0);
      check_field(ch, "rready", 32'(rready[ch]), 32'd0);
      check_field(ch, "bready", 32'(bready[ch]), 32'd0);
      check_field(ch, "data_ok", 32'(cpu_rsp[ch].data_ok), 32'd0);
    end
  endtask

  task automatic kseg1_word_read();
    do_access(0, 1'b0, size_word, 32'ha000_1230, 32'd0);
  endtask

  task automatic kseg0_byte_write();
    // byte lane 1 written and the whole word read back
    do_access(1, 1'b1, size_byte, 32'h8000_2001, 32'h0000_a500);
    do_access(1, 1'b0, size_word, 32'h8000_2000, 32'd0);
  endtask

  task automatic random_sized_traffic();
    logic [31:0]  r;
    logic [31:0]  addr;
    access_size_e size;
    rand_delay = 1'b1;
    for (int i = 0; i < 24; i++) begin
      stim_rng = lcg_next(stim_rng);
      r = stim_rng;
      case (r[21:20])
        2'd0:    addr = 32'h8000_3000;
        2'd1:    addr = 32'ha000_3000;
        2'd2:    addr = 32'h0000_3000;
        default: addr = 32'hc000_3000;
      endcase
      case (r[19:18])
        2'd0:    size = size_byte;
        2'd1:    size = size_half;
        default: size = size_word;
      endcase
      addr = addr | {26'd0, r[27:24], 2'b00};
      if (size == size_byte) addr[1:0] = r[29:28];
      if (size == size_half) addr[1] = r[29];
      stim_rng = lcg_next(stim_rng);
      do_access(int'(r[16]), r[17], size, addr, stim_rng);
    end
    rand_delay = 1'b0;
  endtask

  task automatic dual_channel_traffic();
    // kuseg address with nonzero top bits must pass through untouched
    fork
      do_access(0, 1'b0, size_word, 32'h4000_4000, 32'd0);
      do_access(1, 1'b1, size_word, 32'ha000_5008, 32'hcafe_f00d);
    join
    do_access(1, 1'b0, size_word, 32'ha000_5008, 32'd0);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    rand_delay = 1'b0;
    stim_rng = 32'h525d;
    reset = 1'b1;
    for (int ch = 0; ch < num_channels; ch++) begin
      cpu_req[ch] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_idle_outputs();
    kseg1_word_read();
    kseg0_byte_write();
    random_sized_traffic();
    dual_channel_traffic();
    repeat (2) @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (num_tests * cycles_per_test) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", num_tests * cycles_per_test);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/mem_bridge_pkg.sv
verilog/seg_map.sv
verilog/sram_axi_bridge.sv
verilog/mem_bridge_top.sv
verif/mem_bridge_chk.sv
verif/mem_bridge_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=mem_bridge_sim
log=sim.log

verilator --binary --timing --assert \
  --top-module mem_bridge_tb \
  -f verilog.f \
  --Mdir "$build_dir" \
  -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log" 2>&1
status=$?
cat "$log"

# a stop from a failed assertion counts as a failing run
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  echo "Something failed" >> "$log"
fi

if grep -q "Something failed" "$log"; then
  echo "result: FAIL"
  exit 1
fi

echo "result: PASS"
exit 0
